// File: clp_config.svh
`ifndef CLP_CONFIG_SVH
`define CLP_CONFIG_SVH

// input feature maps presented per beat
`define CLP_TN 2

// output maps with one lane each
`define CLP_TM 4

// kernel side of the CLP_KSIZE x CLP_KSIZE windows
`define CLP_KSIZE 3

`define CLP_FEAT_W 32      // feature and result width
`define CLP_SCALE_W 32     // fixed-point scaler width
`define CLP_SCALE_FRAC 16  // fraction bits of the scaler

// ternary weight code width
`define CLP_KW 2

`endif

// File: clp_pkg.sv
`include "clp_config.svh"

package clp_pkg;

    // ternary weight codes where both 00 and 10 mean zero
    typedef enum logic [`CLP_KW-1:0] {
        WGT_ZERO  = 2'b00,
        WGT_POS   = 2'b01,
        WGT_ZERO2 = 2'b10,
        WGT_NEG   = 2'b11
    } weight_code_e;

    // accumulation opcodes
    typedef enum logic [1:0] {
        ACC_SINGLE = 2'd0,  // result straight out
        ACC_FIRST  = 2'd1,  // start running sum
        ACC_MID    = 2'd2,  // add to running sum
        ACC_LAST   = 2'd3   // running sum plus result out
    } acc_op_e;

    typedef logic signed [`CLP_FEAT_W-1:0] feat_t;

    typedef feat_t [`CLP_TM-1:0] lane_vec_t;  // one word per output map

    // beat passed between pipeline stages
    typedef struct packed {
        logic      valid;
        acc_op_e   op;
        lane_vec_t data;
    } stage_beat_t;

endpackage

// File: clp_dot_product.sv
`timescale 1ns/1ps
`include "clp_config.svh"

module clp_dot_product import clp_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         enable_i,
    input  acc_op_e      op_i,
    input  feat_t        [`CLP_TN-1:0][`CLP_KSIZE-1:0][`CLP_KSIZE-1:0] feature_i,
    input  weight_code_e [`CLP_TM-1:0][`CLP_TN-1:0][`CLP_KSIZE-1:0][`CLP_KSIZE-1:0] weight_i,
    output stage_beat_t  beat_o
);

    localparam int NPOS  = `CLP_KSIZE * `CLP_KSIZE;
    localparam int GRP   = 1 << $clog2(NPOS);              // leaves per input map after padding
    localparam int NLEAF = GRP * (1 << $clog2(`CLP_TN));   // all leaves of one lane
    localparam int NNODE = 2 * NLEAF - 1;

    function automatic feat_t ternary_sel(feat_t f, weight_code_e w);
        case (w)
            WGT_POS:             ternary_sel = f;
            WGT_NEG:             ternary_sel = -f;
            WGT_ZERO, WGT_ZERO2: ternary_sel = '0;
            default:             ternary_sel = '0;
        endcase
    endfunction

    wire lane_vec_t lane_sum;

    logic      valid_q;
    acc_op_e   op_q;
    lane_vec_t data_q;

    genvar m;
    genvar g;
    genvar i;

    // leaves are grouped by input map, so the lower levels form one tree per map
    // and the upper levels add the map sums together
    generate
        for (m = 0; m < `CLP_TM; m = m + 1) begin : g_lane
            wire feat_t node [NNODE];

            for (g = 0; g < NLEAF; g = g + 1) begin : g_leaf
                localparam int N = g / GRP;  // input map
                localparam int P = g % GRP;  // window position
                if (N < `CLP_TN && P < NPOS) begin : g_sel
                    assign node[NLEAF-1+g] = ternary_sel(
                        feature_i[N][P / `CLP_KSIZE][P % `CLP_KSIZE],
                        weight_i[m][N][P / `CLP_KSIZE][P % `CLP_KSIZE]);
                end else begin : g_pad
                    assign node[NLEAF-1+g] = '0;
                end
            end

            for (i = 0; i < NLEAF - 1; i = i + 1) begin : g_node
                assign node[i] = node[2*i+1] + node[2*i+2];
            end

            assign lane_sum[m] = node[0];  // tree root
        end
    endgenerate

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            op_q    <= ACC_SINGLE;
        end else begin
            valid_q <= enable_i;
            op_q    <= op_i;
        end
    end

    always_ff @(posedge clk) begin
        if (enable_i) begin
            data_q <= lane_sum;
        end
    end

    assign beat_o = '{valid: valid_q, op: op_q, data: data_q};

    a_op_known: assert property (
        @(posedge clk) disable iff (!rst_n) enable_i |-> !$isunknown(op_i)
    ) else $error("opcode unknown on an enabled beat");

endmodule

// File: clp_scale_bias.sv
`timescale 1ns/1ps
`include "clp_config.svh"

module clp_scale_bias import clp_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  stage_beat_t             beat_i,
    input  logic [`CLP_SCALE_W-1:0] scaler_i,
    input  lane_vec_t               bias_i,
    output stage_beat_t             beat_o
);

    localparam int PROD_W = `CLP_FEAT_W + `CLP_SCALE_W;

    logic signed [PROD_W-1:0] prod [`CLP_TM];
    lane_vec_t                scaled;

    // step 1 registers
    logic      s1_valid;
    acc_op_e   s1_op;
    lane_vec_t s1_scaled;
    lane_vec_t s1_bias;

    // step 2 registers
    logic      s2_valid;
    acc_op_e   s2_op;
    lane_vec_t s2_data;

    always_comb begin
        for (int l = 0; l < `CLP_TM; l++) begin
            prod[l]   = $signed(beat_i.data[l]) * $signed(scaler_i);  // full width product
            scaled[l] = feat_t'(prod[l] >>> `CLP_SCALE_FRAC);        // drop fraction and keep low word
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_op    <= ACC_SINGLE;
            s2_valid <= 1'b0;
            s2_op    <= ACC_SINGLE;
        end else begin
            s1_valid <= beat_i.valid;
            s1_op    <= beat_i.op;
            s2_valid <= s1_valid;
            s2_op    <= s1_op;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_i.valid) begin
            s1_scaled <= scaled;
            s1_bias   <= bias_i;  // bias follows its beat
        end
        if (s1_valid) begin
            for (int l = 0; l < `CLP_TM; l++) begin
                s2_data[l] <= s1_scaled[l] + s1_bias[l];  // wraps
            end
        end
    end

    assign beat_o = '{valid: s2_valid, op: s2_op, data: s2_data};

endmodule

// File: clp_accumulate.sv
`timescale 1ns/1ps
`include "clp_config.svh"

module clp_accumulate import clp_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  stage_beat_t beat_i,
    output logic        out_valid_o,
    output lane_vec_t   feature_o
);

    lane_vec_t acc_q;      // running sums per lane
    lane_vec_t chain_sum;
    lane_vec_t feat_q;
    logic      open_q;     // a chain has started
    logic      out_valid_q;

    always_comb begin
        for (int l = 0; l < `CLP_TM; l++) begin
            chain_sum[l] = acc_q[l] + beat_i.data[l];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
            open_q      <= 1'b0;
            acc_q       <= '0;
        end else begin
            out_valid_q <= beat_i.valid &&
                           (beat_i.op == ACC_SINGLE || beat_i.op == ACC_LAST);
            if (beat_i.valid) begin
                case (beat_i.op)
                    ACC_FIRST: begin
                        acc_q  <= beat_i.data;
                        open_q <= 1'b1;
                    end
                    ACC_MID:  acc_q  <= chain_sum;
                    ACC_LAST: open_q <= 1'b0;  // chain closed
                    default: ;
                endcase
            end
        end
    end

    // output word holds between pulses
    always_ff @(posedge clk) begin
        if (beat_i.valid) begin
            case (beat_i.op)
                ACC_SINGLE: feat_q <= beat_i.data;
                ACC_LAST:   feat_q <= chain_sum;
                default: ;
            endcase
        end
    end

    assign out_valid_o = out_valid_q;
    assign feature_o   = feat_q;

    a_chain_open: assert property (
        @(posedge clk) disable iff (!rst_n)
        beat_i.valid && (beat_i.op inside {ACC_MID, ACC_LAST}) |-> open_q
    ) else $error("middle or last beat without a first beat");

    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(out_valid_o)
    ) else $error("out_valid_o unknown");

endmodule

// File: clp_top.sv
`timescale 1ns/1ps
`include "clp_config.svh"

module clp_top import clp_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    enable_i,
    input  acc_op_e                 ctr_i,
    input  feat_t                   [`CLP_TN-1:0][`CLP_KSIZE-1:0][`CLP_KSIZE-1:0] feature_i,
    input  weight_code_e            [`CLP_TM-1:0][`CLP_TN-1:0][`CLP_KSIZE-1:0][`CLP_KSIZE-1:0]
                                    weight_i,
    input  logic [`CLP_SCALE_W-1:0] scaler_i,
    input  lane_vec_t               bias_i,
    output logic                    out_valid_o,
    output lane_vec_t               feature_o
);

    stage_beat_t             dp_beat;
    stage_beat_t             sb_beat;
    logic [`CLP_SCALE_W-1:0] scaler_d;
    lane_vec_t               bias_d;

    // scaler and bias meet their beat one cycle later, after the dot product
    always_ff @(posedge clk) begin
        scaler_d <= scaler_i;
        bias_d   <= bias_i;
    end

    clp_dot_product i_dot_product (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable_i  (enable_i),
        .op_i      (ctr_i),
        .feature_i (feature_i),
        .weight_i  (weight_i),
        .beat_o    (dp_beat)
    );

    clp_scale_bias i_scale_bias (
        .clk      (clk),
        .rst_n    (rst_n),
        .beat_i   (dp_beat),
        .scaler_i (scaler_d),
        .bias_i   (bias_d),
        .beat_o   (sb_beat)
    );

    clp_accumulate i_accumulate (
        .clk         (clk),
        .rst_n       (rst_n),
        .beat_i      (sb_beat),
        .out_valid_o (out_valid_o),
        .feature_o   (feature_o)
    );

endmodule

// File: tb_clp.sv
`timescale 1ns/1ps
`include "clp_config.svh"

module tb_clp import clp_pkg::*; ();

    typedef feat_t [`CLP_TN-1:0][`CLP_KSIZE-1:0][`CLP_KSIZE-1:0] feat_win_t;
    typedef weight_code_e [`CLP_TM-1:0][`CLP_TN-1:0][`CLP_KSIZE-1:0][`CLP_KSIZE-1:0] wgt_set_t;

    localparam int PAT_POS   = 0;
    localparam int PAT_NEG   = 1;
    localparam int PAT_ZERO  = 2;
    localparam int PAT_ZERO2 = 3;
    localparam int PAT_RAND  = 4;

    localparam logic [31:0] SC_ONE   = 32'h0001_0000;  // 1.0 in q16
    localparam logic [31:0] SC_HALF  = 32'h0000_8000;
    localparam logic [31:0] SC_1P5   = 32'h0001_8000;
    localparam logic [31:0] SC_3QTR  = 32'h0000_c000;

    logic                    clk;
    logic                    rst_n;
    logic                    enable_i;
    acc_op_e                 ctr_i;
    feat_win_t               feature_i;
    wgt_set_t                weight_i;
    logic [`CLP_SCALE_W-1:0] scaler_i;
    lane_vec_t               bias_i;
    logic                    out_valid_o;
    lane_vec_t               feature_o;

    // stimulus table with one row per beat
    string       name_q   [$];
    acc_op_e     op_q     [$];
    int          pat_q    [$];
    logic [31:0] scaler_q [$];
    int          bias_q   [$];

    // outputs still to come from the DUT
    string       exp_name_q  [$];
    lane_vec_t   exp_val_q   [$];
    int          exp_cycle_q [$];

    int          cycle;
    int          cycle_limit;
    int          pass_cnt;
    int          fail_cnt;
    int unsigned seed_ret;

    feat_win_t   feat_v;
    wgt_set_t    wgt_v;
    lane_vec_t   bias_v;
    lane_vec_t   res_v;
    lane_vec_t   run_sum;  // model of the running sums

    clp_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable_i    (enable_i),
        .ctr_i       (ctr_i),
        .feature_i   (feature_i),
        .weight_i    (weight_i),
        .scaler_i    (scaler_i),
        .bias_i      (bias_i),
        .out_valid_o (out_valid_o),
        .feature_o   (feature_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic add_row(string name, acc_op_e op, int pat, logic [31:0] scaler, int bias);
        name_q.push_back(name);
        op_q.push_back(op);
        pat_q.push_back(pat);
        scaler_q.push_back(scaler);
        bias_q.push_back(bias);
    endtask

    function automatic wgt_set_t make_weights(int pat);
        wgt_set_t w;
        for (int m = 0; m < `CLP_TM; m++)
            for (int n = 0; n < `CLP_TN; n++)
                for (int r = 0; r < `CLP_KSIZE; r++)
                    for (int c = 0; c < `CLP_KSIZE; c++) begin
                        case (pat)
                            PAT_POS:   w[m][n][r][c] = WGT_POS;
                            PAT_NEG:   w[m][n][r][c] = WGT_NEG;
                            PAT_ZERO:  w[m][n][r][c] = WGT_ZERO;
                            PAT_ZERO2: w[m][n][r][c] = WGT_ZERO2;
                            default:   w[m][n][r][c] = weight_code_e'($urandom % 4);
                        endcase
                    end
        return w;
    endfunction

    // R adds the bias to the low word of (S * scaler) >>> frac for the selected sum S
    function automatic lane_vec_t model_result(feat_win_t f, wgt_set_t w,
                                               logic [31:0] scaler, lane_vec_t bias);
        lane_vec_t res;
        feat_t     s;
        longint    prod;
        for (int m = 0; m < `CLP_TM; m++) begin
            s = '0;
            for (int n = 0; n < `CLP_TN; n++)
                for (int r = 0; r < `CLP_KSIZE; r++)
                    for (int c = 0; c < `CLP_KSIZE; c++) begin
                        if (w[m][n][r][c] == WGT_POS)
                            s = s + f[n][r][c];
                        else if (w[m][n][r][c] == WGT_NEG)
                            s = s - f[n][r][c];
                    end
            prod   = longint'(s) * longint'($signed(scaler));
            res[m] = feat_t'(prod >>> `CLP_SCALE_FRAC) + bias[m];
        end
        return res;
    endfunction

    // pairs each output pulse with the oldest expected vector
    always @(negedge clk) begin
        string     name;
        lane_vec_t val;
        int        ecyc;
        bit        ok;
        if (rst_n && out_valid_o === 1'b1) begin
            assert (exp_val_q.size() != 0) else begin
                $display("output pulse in cycle %0d with no beat expecting it", cycle);
                fail_cnt++;
            end
            if (exp_val_q.size() != 0) begin
                name = exp_name_q.pop_front();
                val  = exp_val_q.pop_front();
                ecyc = exp_cycle_q.pop_front();
                ok   = 1'b1;
                assert (cycle == ecyc) else begin
                    $display("error: %s latency, expected cycle %0d, actual cycle %0d",
                             name, ecyc, cycle);
                    ok = 1'b0;
                end
                assert (feature_o == val) else begin
                    $display("error: %s expected %h actual %h", name, val, feature_o);
                    ok = 1'b0;
                end
                if (ok) begin
                    pass_cnt++;
                    $display("test %s passed", name);
                end else begin
                    fail_cnt++;
                    $display("test %s failed", name);
                end
            end
        end
    end

    initial begin
        bit idle_ok;
        clk       = 1'b0;
        rst_n     = 1'b0;
        enable_i  = 1'b0;
        ctr_i     = ACC_SINGLE;
        feature_i = '0;
        weight_i  = '0;
        scaler_i  = '0;
        bias_i    = '0;
        cycle     = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        run_sum   = '0;
        seed_ret  = $urandom(32'hcd73);

        add_row("single_pos",     ACC_SINGLE, PAT_POS,   SC_ONE,  0);
        add_row("single_neg",     ACC_SINGLE, PAT_NEG,   SC_ONE,  0);
        add_row("single_zero",    ACC_SINGLE, PAT_ZERO,  SC_ONE,  5);
        add_row("single_zero2",   ACC_SINGLE, PAT_ZERO2, SC_ONE,  -3);
        add_row("single_mix_a",   ACC_SINGLE, PAT_RAND,  SC_ONE,  11);
        add_row("single_mix_b",   ACC_SINGLE, PAT_RAND,  SC_ONE,  0);
        add_row("scale_half",     ACC_SINGLE, PAT_RAND,  SC_HALF, 0);
        add_row("scale_half_neg", ACC_SINGLE, PAT_NEG,   SC_HALF, 1);
        add_row("bias_neg",       ACC_SINGLE, PAT_RAND,  SC_ONE,  -250);
        add_row("chain_a_first",  ACC_FIRST,  PAT_RAND,  SC_ONE,  2);
        add_row("chain_a_mid1",   ACC_MID,    PAT_RAND,  SC_HALF, -1);
        add_row("chain_a_mid2",   ACC_MID,    PAT_POS,   SC_ONE,  0);
        add_row("chain_a_last",   ACC_LAST,   PAT_RAND,  SC_ONE,  3);
        add_row("mix_single_a",   ACC_SINGLE, PAT_RAND,  SC_1P5,  7);
        add_row("chain_b_first",  ACC_FIRST,  PAT_NEG,   SC_ONE,  -9);
        add_row("mix_single_b",   ACC_SINGLE, PAT_RAND,  SC_HALF, 0);  // inside chain_b
        add_row("chain_b_last",   ACC_LAST,   PAT_RAND,  SC_3QTR, 4);
        add_row("tail_single",    ACC_SINGLE, PAT_RAND,  SC_ONE,  -100);
        cycle_limit = (name_q.size() + 10) * 2;

        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        idle_ok = 1'b1;
        repeat (4) begin
            @(negedge clk);
            assert (out_valid_o === 1'b0) else begin
                $display("out_valid_o went high after reset with no beat applied");
                idle_ok = 1'b0;
            end
        end
        if (idle_ok) begin
            pass_cnt++;
            $display("test idle_after_reset passed");
        end else begin
            fail_cnt++;
            $display("test idle_after_reset failed");
        end

        for (int i = 0; i < name_q.size(); i++) begin
            @(posedge clk);
            #1;
            for (int n = 0; n < `CLP_TN; n++)
                for (int r = 0; r < `CLP_KSIZE; r++)
                    for (int c = 0; c < `CLP_KSIZE; c++)
                        feat_v[n][r][c] = feat_t'(int'($urandom % 2001) - 1000);
            wgt_v = make_weights(pat_q[i]);
            for (int l = 0; l < `CLP_TM; l++)
                bias_v[l] = feat_t'(bias_q[i] * (l + 1));  // distinct bias per map
            enable_i  = 1'b1;
            ctr_i     = op_q[i];
            feature_i = feat_v;
            weight_i  = wgt_v;
            scaler_i  = scaler_q[i];
            bias_i    = bias_v;
            res_v     = model_result(feat_v, wgt_v, scaler_q[i], bias_v);
            case (op_q[i])
                ACC_FIRST: run_sum = res_v;
                ACC_MID: begin
                    for (int l = 0; l < `CLP_TM; l++)
                        run_sum[l] = run_sum[l] + res_v[l];
                end
                ACC_LAST: begin
                    for (int l = 0; l < `CLP_TM; l++)
                        res_v[l] = run_sum[l] + res_v[l];
                end
                default: ;
            endcase
            if (op_q[i] == ACC_SINGLE || op_q[i] == ACC_LAST) begin
                exp_name_q.push_back(name_q[i]);
                exp_val_q.push_back(res_v);
                exp_cycle_q.push_back(cycle + 4);
            end
        end
        @(posedge clk);
        #1 enable_i = 1'b0;

        while (exp_val_q.size() > 0)
            @(posedge clk);
        repeat (3) @(posedge clk);  // catch stray pulses

        $display("tests: %0d  passed: %0d  failed: %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
clp_pkg.sv
clp_dot_product.sv
clp_scale_bias.sv
clp_accumulate.sv
clp_top.sv
tb_clp.sv

// File: Bender.yml
package:
  name: clp_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - clp_pkg.sv
      - clp_dot_product.sv
      - clp_scale_bias.sv
      - clp_accumulate.sv
      - clp_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_clp.sv
